// File: bench/mem_pipe_tb.sv
// ---------------------------------------------------------------------
// testbench for the memory stage top: file driven stimulus and checks
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_pipe_tb;

    import rv32i_types_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int COLS      = 6;                  // values per stimulus line
    localparam int MEM_WAIT  = `DMEM_LATENCY + 1;  // edges with mem_rdy low for a memory op

    logic        clk;
    logic        rst;
    logic        exe_valid;
    logic        mem_read;
    logic        mem_write;
    mem_width_e  funct3;
    addr_t       alu_out;
    word_t       store_data;
    logic        mem_rdy;
    logic        wb_valid;
    word_t       wb_data;

    logic [31:0] stim [MAX_LINES*COLS];  // all ones marks the end of the file
    int          num_lines;
    int          cycle_limit;            // zero until the stimulus is counted
    int          cycles;

    mem_pipe_top UUT (
        .clk        (clk),
        .rst        (rst),
        .exe_valid  (exe_valid),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .funct3     (funct3),
        .alu_out    (alu_out),
        .store_data (store_data),
        .mem_rdy    (mem_rdy),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data)
    );

    always #10 clk = ~clk;  // 20 ns period

    // run limit, a stuck handshake ends here
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout waiting for mem_rdy");
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    initial begin
        int          i;
        int          n;
        int          lat;        // rising edges seen with mem_rdy low
        int          exp_lat;
        logic        prev_mem;   // last instruction went to memory
        logic [31:0] expected;

        clk         = 1'b0;
        rst         = 1'b1;
        exe_valid   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        funct3      = LB;
        alu_out     = '0;
        store_data  = '0;
        cycles      = 0;
        cycle_limit = 0;
        prev_mem    = 1'b0;

        for (i = 0; i < MAX_LINES*COLS; i++) begin
            stim[i] = 32'hffff_ffff;
        end
        $readmemh("bench/mem_stim.txt", stim);
        num_lines = 0;
        while (num_lines < MAX_LINES && stim[num_lines*COLS] != 32'hffff_ffff) begin
            num_lines++;
        end
        cycle_limit = num_lines * (`DMEM_LATENCY + 4) + 8 + 50;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle fields, ready only reflects the missing memory op
        repeat (4) begin
            @(negedge clk);
            expect_equal("mem_rdy", mem_rdy, 1);
            expect_equal("wb_valid", wb_valid, 0);
        end

        for (n = 0; n < num_lines; n++) begin
            exe_valid  = 1'b1;  // fields change on the falling edge
            mem_read   = stim[n*COLS][0];
            mem_write  = stim[n*COLS+1][0];
            funct3     = mem_width_e'(stim[n*COLS+2][2:0]);
            alu_out    = stim[n*COLS+3];
            store_data = stim[n*COLS+4];
            expected   = stim[n*COLS+5];
            // strobe is held back one cycle right after a response
            exp_lat    = (mem_read || mem_write) ? MEM_WAIT + prev_mem : 0;
            lat        = 0;
            #1;
            while (!mem_rdy) begin
                @(negedge clk);
                expect_equal("wb_valid", wb_valid, 0);  // no pulse while stalled
                lat++;
                #1;
            end
            expect_equal("mem_rdy latency", lat, exp_lat);
            @(negedge clk);  // handover edge has passed
            expect_equal("wb_valid", wb_valid, 1);
            if (!mem_write) begin
                expect_equal("wb_data", wb_data, expected);
            end
            prev_mem = mem_read || mem_write;
        end

        exe_valid = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        @(negedge clk);
        expect_equal("wb_valid", wb_valid, 0);  // one pulse per instruction only

        $display("sim passed");
        $finish;
    end

endmodule

// File: bench/mem_stim.txt
// mem_read mem_write funct3 alu_out store_data expected_wb_data
// stores keep a zero last column, non memory ops expect alu_out back
0 1 2 00000000 11223344 00000000
0 1 2 00000004 55667788 00000000
0 1 2 00000008 99aabbcc 00000000
0 1 2 0000000c ddeeff00 00000000
0 1 2 00000010 0badf00d 00000000
1 0 2 0000000c 00000000 ddeeff00
1 0 2 00000000 00000000 11223344
1 0 2 00000008 00000000 99aabbcc
1 0 2 00000010 00000000 0badf00d
1 0 2 00000004 00000000 55667788
0 0 0 deadbeef 00000000 deadbeef
0 0 5 00000123 ffffffff 00000123
0 1 2 00000020 00000000 00000000
0 1 0 00000021 123456a5 00000000
0 1 1 00000022 7777beef 00000000
0 1 0 00000020 abcdef12 00000000
1 0 2 00000020 00000000 beefa512
1 0 0 00000020 00000000 00000012
1 0 0 00000021 00000000 ffffffa5
1 0 4 00000021 00000000 000000a5
1 0 1 00000022 00000000 ffffbeef
1 0 5 00000022 00000000 0000beef
1 0 1 00000020 00000000 ffffa512
1 0 0 00000023 00000000 ffffffbe
1 0 4 00000022 00000000 000000ef
0 0 0 cafef00d 00000000 cafef00d
0 1 2 00000034 7f7f8080 00000000
1 0 1 00000036 00000000 00007f7f
1 0 0 00000034 00000000 ffffff80
1 0 4 00000035 00000000 00000080
1 0 5 00000034 00000000 00008080
1 0 0 00000037 00000000 0000007f
0 0 2 00000000 00000000 00000000
1 0 2 00000034 00000000 7f7f8080
1 0 2 00000000 00000000 11223344

// File: design/dcache_port.sv
// ---------------------------------------------------------------------
// data memory request port with capture, bank/lane decode, delay and response
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "mem_defs.svh"

module dcache_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mem_r_d,
    input  logic                        mem_w_d,
    input  rv32i_types_pkg::addr_t      addr,
    input  rv32i_types_pkg::word_t      wdata,
    input  rv32i_types_pkg::mem_width_e funct3,
    output logic                        mem_resp_d,
    output logic [`NUM_BANKS-1:0]       bank_sel,   // one hot
    output logic                        bank_we,
    output logic                        bank_re,
    output dmem_types_pkg::bank_addr_t  bank_addr,
    output rv32i_types_pkg::word_t      bank_wdata,
    output rv32i_types_pkg::byte_en_t   bank_be,
    output dmem_types_pkg::bank_idx_t   resp_bank,  // for load_align
    output logic [1:0]                  resp_lane
);

    import rv32i_types_pkg::*;
    import dmem_types_pkg::*;

    localparam int LANE_W = 2;
    localparam int IDX_W  = $bits(bank_idx_t);
    localparam int CNT_W  = $clog2(`DMEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DMEM_LATENCY - 1);

    port_state_e      state;
    logic [CNT_W-1:0] cnt;         // cycles spent in WAIT
    logic             resp_q;
    logic             req;         // any strobe up
    logic             cap;         // request taken this edge
    logic             is_half;
    logic             is_word;
    logic             wr_q;        // captured op is a store
    byte_en_t         be_next;
    bank_idx_t        idx_q;
    logic [1:0]       lane_q;

    assign req = mem_r_d || mem_w_d;
    assign cap = (state == IDLE) && req;

    assign is_half = (funct3 == LH) || (funct3 == LHU);
    assign is_word = (funct3 == LW);  // SW shares the code

    // byte lane mask from access size and low address bits
    always_comb begin
        case (funct3)
            SB, LBU: be_next = byte_en_t'(4'b0001) << addr[1:0];
            SH, LHU: be_next = byte_en_t'(4'b0011) << addr[1:0];
            default: be_next = '1; // word
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            cnt    <= '0;
            resp_q <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state)
                IDLE: if (req) begin
                    state <= WAIT;
                    cnt   <= '0;
                end
                WAIT: if (cnt == LAST_CNT) begin
                    state  <= RESP;  // bank is accessed on this edge
                    resp_q <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
                RESP:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // request payload held until the next capture
    always_ff @(posedge clk) begin
        if (cap) begin
            wr_q       <= mem_w_d;
            idx_q      <= addr[LANE_W +: IDX_W];
            bank_addr  <= addr[LANE_W + IDX_W +: `BANK_AW];
            lane_q     <= addr[1:0];
            bank_be    <= be_next;
            bank_wdata <= wdata << {addr[1:0], 3'b000}; // store data into its lane
        end
    end

    // access only in the last WAIT cycle
    assign bank_we = (state == WAIT) && (cnt == LAST_CNT) && wr_q;
    assign bank_re = (state == WAIT) && (cnt == LAST_CNT) && !wr_q;

    always_comb begin
        for (int i = 0; i < `NUM_BANKS; i++) begin
            bank_sel[i] = (idx_q == bank_idx_t'(i));
        end
    end

    assign mem_resp_d = resp_q;
    assign resp_bank  = idx_q;
    assign resp_lane  = lane_q;

    a_half_align: assert property (@(posedge clk) disable iff (rst)
        cap && is_half |-> addr[0] == 1'b0)
        else $error("misaligned halfword access at %h", addr);

    a_word_align: assert property (@(posedge clk) disable iff (rst)
        cap && is_word |-> addr[1:0] == 2'b00)
        else $error("misaligned word access at %h", addr);

    // the stage keeps the captured strobe up through the response cycle
    a_resp_state: assert property (@(posedge clk) disable iff (rst)
        mem_resp_d |-> state == RESP && (wr_q ? mem_w_d : mem_r_d))
        else $error("response pulse outside RESP or without its strobe");

endmodule

// File: design/dmem_bank.sv
// ---------------------------------------------------------------------
// one word bank with byte lane writes and a registered read port
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "mem_defs.svh"

module dmem_bank (
    input  logic                       clk,
    input  logic                       sel,    // this bank is addressed
    input  logic                       we,
    input  logic                       re,
    input  dmem_types_pkg::bank_addr_t addr,
    input  rv32i_types_pkg::word_t     wdata,  // already shifted into its lane
    input  rv32i_types_pkg::byte_en_t  be,
    output rv32i_types_pkg::word_t     rdata   // valid the cycle after re
);

    import rv32i_types_pkg::*;

    word_t mem [`BANK_WORDS];  // no reset, stores come before loads

    // only enabled lanes are written, others keep their bytes
    always_ff @(posedge clk) begin
        if (sel && we) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (be[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // read data stays until the next read of this bank
    always_ff @(posedge clk) begin
        if (sel && re) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: design/dmem_types_pkg.sv
// ---------------------------------------------------------------------
// memory side types: bank index, bank word address, port states
// ---------------------------------------------------------------------
`include "mem_defs.svh"

package dmem_types_pkg;

    // picks one of the interleaved banks, address bits 3:2
    typedef logic [$clog2(`NUM_BANKS)-1:0] bank_idx_t;

    // word within a bank, bits above the bank index
    typedef logic [`BANK_AW-1:0] bank_addr_t;

    // request port sequencing
    typedef enum logic [1:0] {
        IDLE, // waiting for a strobe
        WAIT, // counting out the access delay
        RESP  // one cycle response pulse
    } port_state_e;

endpackage

// File: design/load_align.sv
// ---------------------------------------------------------------------
// load data select, lane extract and sign/zero extend, write back register
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "mem_defs.svh"

module load_align (
    input  logic                                     clk,
    input  logic                                     rst,
    input  rv32i_types_pkg::word_t [`NUM_BANKS-1:0]  bank_rdata,
    input  dmem_types_pkg::bank_idx_t                resp_bank,
    input  logic [1:0]                               resp_lane,
    input  rv32i_types_pkg::mem_width_e              funct3,
    input  logic                                     mem_read,
    input  rv32i_types_pkg::word_t                   alu_out,  // result of non memory ops
    input  logic                                     exe_valid,
    input  logic                                     mem_rdy,
    output logic                                     wb_valid,
    output rv32i_types_pkg::word_t                   wb_data
);

    import rv32i_types_pkg::*;

    word_t bank_word;   // word from the responding bank
    word_t lane_word;   // addressed byte/half moved down to bit 0
    word_t load_val;

    assign bank_word = bank_rdata[resp_bank];
    assign lane_word = bank_word >> {resp_lane, 3'b000};

    always_comb begin
        case (funct3)
            LB:      load_val = {{(`XLEN-8){lane_word[7]}}, lane_word[7:0]};
            LH:      load_val = {{(`XLEN-16){lane_word[15]}}, lane_word[15:0]};
            LBU:     load_val = {{(`XLEN-8){1'b0}}, lane_word[7:0]};
            LHU:     load_val = {{(`XLEN-16){1'b0}}, lane_word[15:0]};
            default: load_val = bank_word; // LW
        endcase
    end

    // one pulse per instruction handed over by the stage
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exe_valid && mem_rdy;
        end
    end

    // stores leave whatever alu_out held, nobody reads it
    always_ff @(posedge clk) begin
        if (exe_valid && mem_rdy) begin
            wb_data <= mem_read ? load_val : alu_out;
        end
    end

endmodule

// File: design/mem_defs.svh
// ---------------------------------------------------------------------
// size and timing defines for the data memory and its request port
// ---------------------------------------------------------------------
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data path and byte address width
`define XLEN 32

// word interleaved banks, bank index sits right above the byte lane
`define NUM_BANKS 4

// depth of each bank in words
`define BANK_WORDS 64

// word address bits inside one bank, log2 of BANK_WORDS
`define BANK_AW 6

// cycles spent in WAIT before the bank is touched
`define DMEM_LATENCY 2

`endif

// File: design/mem_pipe_top.sv
// ---------------------------------------------------------------------
// memory stage top: stage control, request port, banks, load aligner
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_pipe_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        exe_valid,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  rv32i_types_pkg::mem_width_e funct3,
    input  rv32i_types_pkg::addr_t      alu_out,    // address for loads/stores
    input  rv32i_types_pkg::word_t      store_data,
    output logic                        mem_rdy,
    output logic                        wb_valid,
    output rv32i_types_pkg::word_t      wb_data
);

    import rv32i_types_pkg::*;
    import dmem_types_pkg::*;

    logic                     mem_r_d;
    logic                     mem_w_d;
    logic                     mem_resp_d;
    logic [`NUM_BANKS-1:0]    bank_sel;
    logic                     bank_we;
    logic                     bank_re;
    bank_addr_t               bank_addr;
    word_t                    bank_wdata;
    byte_en_t                 bank_be;
    bank_idx_t                resp_bank;
    logic [1:0]               resp_lane;
    word_t [`NUM_BANKS-1:0]   bank_rdata;  // one read word per bank

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .exe_valid  (exe_valid),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_resp_d (mem_resp_d),
        .mem_r_d    (mem_r_d),
        .mem_w_d    (mem_w_d),
        .mem_rdy    (mem_rdy)
    );

    dcache_port u_dcache_port (
        .clk        (clk),
        .rst        (rst),
        .mem_r_d    (mem_r_d),
        .mem_w_d    (mem_w_d),
        .addr       (alu_out),
        .wdata      (store_data),
        .funct3     (funct3),
        .mem_resp_d (mem_resp_d),
        .bank_sel   (bank_sel),
        .bank_we    (bank_we),
        .bank_re    (bank_re),
        .bank_addr  (bank_addr),
        .bank_wdata (bank_wdata),
        .bank_be    (bank_be),
        .resp_bank  (resp_bank),
        .resp_lane  (resp_lane)
    );

    // strobes and payload are shared, bank_sel picks the one that acts
    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
        dmem_bank u_bank (
            .clk   (clk),
            .sel   (bank_sel[i]),
            .we    (bank_we),
            .re    (bank_re),
            .addr  (bank_addr),
            .wdata (bank_wdata),
            .be    (bank_be),
            .rdata (bank_rdata[i])
        );
    end

    load_align u_load_align (
        .clk        (clk),
        .rst        (rst),
        .bank_rdata (bank_rdata),
        .resp_bank  (resp_bank),
        .resp_lane  (resp_lane),
        .funct3     (funct3),
        .mem_read   (mem_read),
        .alu_out    (alu_out),
        .exe_valid  (exe_valid),
        .mem_rdy    (mem_rdy),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data)
    );

endmodule

// File: design/mem_stage.sv
// ---------------------------------------------------------------------
// memory stage control: read/write strobes and the ready level
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module mem_stage (
    input  logic clk,
    input  logic rst,
    input  logic exe_valid,   // exe/mem register holds a live instruction
    input  logic mem_read,
    input  logic mem_write,
    input  logic mem_resp_d,  // one cycle pulse from the port
    output logic mem_r_d,     // read strobe, level until response
    output logic mem_w_d,     // write strobe, level until response
    output logic mem_rdy      // stage can hand over to write back
);

    logic mem_op;     // instruction touches memory
    logic resp_flag;  // response seen last cycle

    assign mem_op = mem_read || mem_write;

    // non memory ops are ready at once, memory ops wait for the pulse
    assign mem_rdy = !mem_op || mem_resp_d;

    // the strobe stays up through the response cycle
    // resp_flag drops it for one cycle so a held instruction is not sent again
    always_comb begin
        mem_r_d = 1'b0;
        mem_w_d = 1'b0;
        if (exe_valid && !resp_flag) begin
            mem_r_d = mem_read;
            mem_w_d = mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_flag <= 1'b0;
        end else begin
            resp_flag <= mem_resp_d && mem_op; // only lives for one cycle
        end
    end

    // decode must never flag an op as both load and store
    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_r_d && mem_w_d))
        else $error("read and write strobes high together");

    // a response pulse is never followed by a fresh strobe in the next cycle
    a_no_reissue: assert property (@(posedge clk) disable iff (rst)
        mem_resp_d |=> !(mem_r_d || mem_w_d))
        else $error("strobe reissued right after response");

endmodule

// File: design/rv32i_types_pkg.sv
// ---------------------------------------------------------------------
// instruction side types: data word, address, byte lanes, funct3 widths
// ---------------------------------------------------------------------
`include "mem_defs.svh"

package rv32i_types_pkg;

    typedef logic [`XLEN-1:0] word_t;       // one data word
    typedef logic [`XLEN-1:0] addr_t;       // byte address
    typedef logic [`XLEN/8-1:0] byte_en_t;  // one bit per byte lane

    // funct3 of the load/store opcodes
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } mem_width_e;

    // stores reuse the low funct3 codes
    localparam mem_width_e SB = LB;
    localparam mem_width_e SH = LH;
    localparam mem_width_e SW = LW;

endpackage

// File: mem_pipe_top.f
+incdir+design
design/rv32i_types_pkg.sv
design/dmem_types_pkg.sv
design/mem_stage.sv
design/dcache_port.sv
design/dmem_bank.sv
design/load_align.sv
design/mem_pipe_top.sv
bench/mem_pipe_tb.sv
